/* mempool_pkg.sv */
// MemPool system shell package
// Address map, bus widths, L2 bank geometry and control register offsets
`default_nettype none

package mempool_pkg;

  // Bus types
  typedef logic [31:0] addr_t; // Byte address
  typedef logic [31:0] data_t; // Bus data word
  typedef logic [3:0]  strb_t; // Byte select

  // Control register window, end exclusive
  localparam addr_t CtrlRegistersBaseAddr = 32'h4000_0000;
  localparam addr_t CtrlRegistersEndAddr  = 32'h4001_0000;

  // L2 memory window
  localparam addr_t       L2MemoryBaseAddr = 32'h8000_0000;
  localparam int unsigned L2Size           = 1024; // Bytes

  // Boot ROM window, end inclusive
  localparam addr_t BootromBaseAddr = 32'hA000_0000;
  localparam addr_t BootromEndAddr  = 32'hA000_FFFF;

  // L2 geometry, words interleaved across banks
  localparam int unsigned NumL2Banks      = 4;
  localparam int unsigned L2BankNumWords  = 64;
  localparam int unsigned L2BankAddrWidth = 6;

  localparam int unsigned BootromNumWords = 16;

  // Decoder targets
  typedef enum logic [1:0] {
    Peripherals,
    Bootrom,
    L2Memory,
    NoTarget
  } soc_target_e;

  // Control register byte offsets
  localparam addr_t EocOffset       = 32'h0000_0000;
  localparam addr_t WakeUpOffset    = 32'h0000_0004;
  localparam addr_t TcdmStartOffset = 32'h0000_0008;
  localparam addr_t TcdmEndOffset   = 32'h0000_000C;
  localparam addr_t NumCoresOffset  = 32'h0000_0010;

  // Wake-up value that addresses every core
  localparam data_t WakeAllCores = 32'hFFFF_FFFF;

endpackage : mempool_pkg

`default_nettype wire

/* sys_bus_if.sv */
// Wishbone classic bus between the address decoder and one target
`timescale 1ns/1ns
`default_nettype none

interface sys_bus_if;
  import mempool_pkg::*;

  logic  cyc;
  logic  stb;
  logic  we;
  addr_t adr;   // Offset inside the target window
  data_t dat_w;
  strb_t sel;
  data_t dat_r;
  logic  ack;

  // Decoder side
  modport initiator (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack
  );

  // Memory or register side
  modport target (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack
  );

endinterface : sys_bus_if

`default_nettype wire

/* soc_addr_decoder.sv */
// SoC address decoder
// Routes the external Wishbone bus to one target and answers unmapped accesses with an error
`timescale 1ns/1ns
`default_nettype none

module soc_addr_decoder (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               wb_cyc_i,
  input  wire logic               wb_stb_i,
  input  wire logic               wb_we_i,
  input  wire mempool_pkg::addr_t wb_adr_i,
  input  wire mempool_pkg::data_t wb_dat_i,
  input  wire mempool_pkg::strb_t wb_sel_i,
  output mempool_pkg::data_t      wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    wb_err_o,
  sys_bus_if.initiator            bus_ctrl_o,
  sys_bus_if.initiator            bus_rom_o,
  sys_bus_if.initiator            bus_l2_o
);
  import mempool_pkg::*;

  localparam addr_t L2MemoryEndAddr = L2MemoryBaseAddr + addr_t'(L2Size);

  soc_target_e target;
  logic        sel_ctrl;
  logic        sel_rom;
  logic        sel_l2;
  logic        err_access;
  logic        err_q;

  always_comb begin
    target = NoTarget;
    if (wb_adr_i >= CtrlRegistersBaseAddr && wb_adr_i < CtrlRegistersEndAddr) begin
      target = Peripherals;
    end else if (wb_adr_i >= L2MemoryBaseAddr && wb_adr_i < L2MemoryEndAddr) begin
      target = L2Memory;
    end else if (wb_adr_i >= BootromBaseAddr && wb_adr_i <= BootromEndAddr) begin
      target = Bootrom;
    end
  end

  assign sel_ctrl   = (target == Peripherals);
  assign sel_l2     = (target == L2Memory);
  assign sel_rom    = (target == Bootrom) && !wb_we_i; // ROM is read only
  assign err_access = (target == NoTarget) || ((target == Bootrom) && wb_we_i);

  assign bus_ctrl_o.cyc   = wb_cyc_i & sel_ctrl;
  assign bus_ctrl_o.stb   = wb_stb_i & sel_ctrl;
  assign bus_ctrl_o.we    = wb_we_i;
  assign bus_ctrl_o.adr   = sel_ctrl ? wb_adr_i - CtrlRegistersBaseAddr : '0;
  assign bus_ctrl_o.dat_w = wb_dat_i;
  assign bus_ctrl_o.sel   = wb_sel_i;

  assign bus_rom_o.cyc   = wb_cyc_i & sel_rom;
  assign bus_rom_o.stb   = wb_stb_i & sel_rom;
  assign bus_rom_o.we    = wb_we_i;
  assign bus_rom_o.adr   = sel_rom ? wb_adr_i - BootromBaseAddr : '0;
  assign bus_rom_o.dat_w = wb_dat_i;
  assign bus_rom_o.sel   = wb_sel_i;

  assign bus_l2_o.cyc   = wb_cyc_i & sel_l2;
  assign bus_l2_o.stb   = wb_stb_i & sel_l2;
  assign bus_l2_o.we    = wb_we_i;
  assign bus_l2_o.adr   = sel_l2 ? wb_adr_i - L2MemoryBaseAddr : '0;
  assign bus_l2_o.dat_w = wb_dat_i;
  assign bus_l2_o.sel   = wb_sel_i;

  // Error pulse with the same latency as a target ack
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= wb_cyc_i & wb_stb_i & err_access & ~err_q;
    end
  end

  always_comb begin
    case (target)
      Peripherals: wb_dat_o = bus_ctrl_o.dat_r;
      Bootrom:     wb_dat_o = bus_rom_o.dat_r;
      L2Memory:    wb_dat_o = bus_l2_o.dat_r;
      default:     wb_dat_o = '0;
    endcase
  end

  assign wb_ack_o = bus_ctrl_o.ack | bus_rom_o.ack | bus_l2_o.ack;
  assign wb_err_o = err_q;

endmodule : soc_addr_decoder

`default_nettype wire

/* l2_mem.sv */
// Banked L2 memory
// Consecutive words go to consecutive banks, writes honour the byte selects
`timescale 1ns/1ns
`default_nettype none

module l2_mem (
  input wire logic   clk_i,
  input wire logic   rst_n_i,
  sys_bus_if.target  bus_i
);
  import mempool_pkg::*;

  localparam int unsigned BankSelWidth = $clog2(NumL2Banks);
  localparam int unsigned RowLsb       = 2 + BankSelWidth; // Above the byte and bank bits
  localparam int unsigned NumBytes     = $bits(strb_t);

  typedef logic [BankSelWidth-1:0]    bank_sel_t;
  typedef logic [L2BankAddrWidth-1:0] row_t;

  logic      req;
  logic      ack_q;
  bank_sel_t bank_sel;
  bank_sel_t bank_sel_q;
  row_t      row;
  data_t     bank_rdata [NumL2Banks];

  // New strobe only, so one strobe gets one ack
  assign req      = bus_i.cyc & bus_i.stb & ~ack_q;
  assign bank_sel = bus_i.adr[2 +: BankSelWidth];
  assign row      = bus_i.adr[RowLsb +: L2BankAddrWidth];

  for (genvar b = 0; b < NumL2Banks; b++) begin : gen_banks
    data_t mem [L2BankNumWords];
    logic  bank_req;

    assign bank_req = req && (bank_sel == bank_sel_t'(b));

    always_ff @(posedge clk_i) begin
      if (bank_req) begin
        if (bus_i.we) begin
          for (int i = 0; i < NumBytes; i++) begin
            if (bus_i.sel[i]) begin
              mem[row][8*i +: 8] <= bus_i.dat_w[8*i +: 8];
            end
          end
        end
        bank_rdata[b] <= mem[row]; // Registered row
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // Bank that answers in the ack cycle
  always_ff @(posedge clk_i) begin
    if (req) begin
      bank_sel_q <= bank_sel;
    end
  end

  assign bus_i.dat_r = bank_rdata[bank_sel_q];
  assign bus_i.ack   = ack_q;

endmodule : l2_mem

`default_nettype wire

/* bootrom.sv */
// Boot ROM
// Read-only words loaded from bootrom.hex, the index wraps inside the ROM
`timescale 1ns/1ns
`default_nettype none

module bootrom (
  input wire logic   clk_i,
  input wire logic   rst_n_i,
  sys_bus_if.target  bus_i
);
  import mempool_pkg::*;

  localparam int unsigned IdxWidth = $clog2(BootromNumWords);

  data_t               rom [BootromNumWords];
  logic [IdxWidth-1:0] idx;
  logic                req;
  logic                ack_q;
  data_t               rdata_q;

  initial begin
    $readmemh("bootrom.hex", rom);
  end

  assign req = bus_i.cyc & bus_i.stb & ~ack_q;
  assign idx = bus_i.adr[2 +: IdxWidth]; // Word index modulo ROM depth

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      rdata_q <= rom[idx];
    end
  end

  assign bus_i.dat_r = rdata_q;
  assign bus_i.ack   = ack_q;

endmodule : bootrom

`default_nettype wire

/* ctrl_registers.sv */
// Control registers
// End of computation, wake-up pulses and read-only system information
`timescale 1ns/1ns
`default_nettype none

module ctrl_registers #(
  parameter int unsigned        NumCores     = 8,
  parameter mempool_pkg::addr_t TCDMBaseAddr = 32'h0000_0000,
  parameter mempool_pkg::addr_t TCDMSize     = 32'h0001_0000
) (
  input  wire logic        clk_i,
  input  wire logic        rst_n_i,
  sys_bus_if.target        bus_i,
  output logic             eoc_valid_o,
  output logic [NumCores-1:0] wake_up_o
);
  import mempool_pkg::*;

  localparam int unsigned         NumBytes  = $bits(strb_t);
  localparam logic [NumCores-1:0] FirstCore = 1;

  logic                req;
  logic                wr;
  logic                ack_q;
  addr_t               offset;
  data_t               rdata_d;
  data_t               rdata_q;
  data_t               eoc_q;
  logic [NumCores-1:0] wake_d;
  logic [NumCores-1:0] wake_up_q;

  assign req    = bus_i.cyc & bus_i.stb & ~ack_q;
  assign wr     = req & bus_i.we;
  assign offset = {bus_i.adr[31:2], 2'b00}; // Word aligned

  // Core index, all cores, or nobody
  always_comb begin
    if (bus_i.dat_w == WakeAllCores) begin
      wake_d = '1;
    end else if (bus_i.dat_w < NumCores) begin
      wake_d = FirstCore << bus_i.dat_w;
    end else begin
      wake_d = '0;
    end
  end

  always_comb begin
    case (offset)
      EocOffset:       rdata_d = eoc_q;
      TcdmStartOffset: rdata_d = TCDMBaseAddr;
      TcdmEndOffset:   rdata_d = TCDMBaseAddr + TCDMSize;
      NumCoresOffset:  rdata_d = data_t'(NumCores);
      default:         rdata_d = '0; // Wake-up is write only
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q     <= 1'b0;
      eoc_q     <= '0;
      wake_up_q <= '0;
    end else begin
      ack_q <= req;
      if (wr && offset == EocOffset) begin
        for (int i = 0; i < NumBytes; i++) begin
          if (bus_i.sel[i]) begin
            eoc_q[8*i +: 8] <= bus_i.dat_w[8*i +: 8];
          end
        end
      end
      // Pulse lasts for the ack cycle only
      wake_up_q <= (wr && offset == WakeUpOffset) ? wake_d : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus_i.dat_r = rdata_q;
  assign bus_i.ack   = ack_q;
  assign eoc_valid_o = eoc_q[0];
  assign wake_up_o   = wake_up_q;

endmodule : ctrl_registers

`default_nettype wire

/* mempool_system.sv */
// MemPool system shell
// External Wishbone port decoded onto L2 memory, boot ROM and control registers
`timescale 1ns/1ns
`default_nettype none

module mempool_system #(
  parameter int unsigned        NumCores     = 8,
  parameter mempool_pkg::addr_t TCDMBaseAddr = 32'h0000_0000,
  parameter mempool_pkg::addr_t TCDMSize     = 32'h0001_0000
) (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               wb_cyc_i,
  input  wire logic               wb_stb_i,
  input  wire logic               wb_we_i,
  input  wire mempool_pkg::addr_t wb_adr_i,
  input  wire mempool_pkg::data_t wb_dat_i,
  input  wire mempool_pkg::strb_t wb_sel_i,
  output mempool_pkg::data_t      wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    wb_err_o,
  output logic                    eoc_valid_o,
  output logic [NumCores-1:0]     wake_up_o
);

  sys_bus_if bus_ctrl ();
  sys_bus_if bus_rom ();
  sys_bus_if bus_l2 ();

  soc_addr_decoder u_soc_addr_decoder (
    .clk_i     (clk_i   ),
    .rst_n_i   (rst_n_i ),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i ),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_sel_i  (wb_sel_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .wb_err_o  (wb_err_o),
    .bus_ctrl_o(bus_ctrl),
    .bus_rom_o (bus_rom ),
    .bus_l2_o  (bus_l2  )
  );

  l2_mem u_l2_mem (
    .clk_i  (clk_i  ),
    .rst_n_i(rst_n_i),
    .bus_i  (bus_l2 )
  );

  bootrom u_bootrom (
    .clk_i  (clk_i  ),
    .rst_n_i(rst_n_i),
    .bus_i  (bus_rom)
  );

  ctrl_registers #(
    .NumCores    (NumCores    ),
    .TCDMBaseAddr(TCDMBaseAddr),
    .TCDMSize    (TCDMSize    )
  ) u_ctrl_registers (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .bus_i      (bus_ctrl   ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

endmodule : mempool_system

`default_nettype wire

/* tb_mempool_system_asserts.sv */
// Protocol assertions for the MemPool system top-level bus
`timescale 1ns/1ns
`default_nettype none

module tb_mempool_system_asserts #(
  parameter int unsigned NumCores = 8
) (
  input wire logic                clk_i,
  input wire logic                rst_n_i,
  input wire logic                cyc_i,
  input wire logic                stb_i,
  input wire logic                ack_i,
  input wire logic                err_i,
  input wire logic [NumCores-1:0] wake_up_i
);

  // One response kind per access
  ack_err_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(ack_i && err_i)) else $error("ack and err high in the same cycle");

  response_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ack_i || err_i) |-> (cyc_i && stb_i)) else $error("response without an active strobe");

  ack_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ack_i |=> !ack_i) else $error("ack longer than one cycle");

  err_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    err_i |=> !err_i) else $error("err longer than one cycle");

  // Wake-up pulse rides on the register write ack
  wake_only_on_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wake_up_i != '0) |-> ack_i) else $error("wake_up outside an ack cycle");

endmodule : tb_mempool_system_asserts

bind mempool_system tb_mempool_system_asserts #(
  .NumCores(NumCores)
) u_asserts (
  .clk_i    (clk_i    ),
  .rst_n_i  (rst_n_i  ),
  .cyc_i    (wb_cyc_i ),
  .stb_i    (wb_stb_i ),
  .ack_i    (wb_ack_o ),
  .err_i    (wb_err_o ),
  .wake_up_i(wake_up_o)
);

`default_nettype wire

/* tb_mempool_system.sv */
// Testbench for the MemPool system shell
// Applies a table of bus accesses and checks data, errors, EOC and wake-up pulses
`timescale 1ns/1ns
`default_nettype none

module tb_mempool_system;
  import mempool_pkg::*;

  localparam int unsigned NumCores     = 8;
  localparam addr_t       TCDMBaseAddr = 32'h0010_0000;
  localparam addr_t       TCDMSize     = 32'h0002_0000;
  localparam int unsigned ClkHalf      = 10;
  localparam int unsigned ResetCycles  = 10;
  localparam int unsigned MaxWait      = 4; // Cycles before an access counts as lost

  typedef struct packed {
    logic                we;
    addr_t               adr;
    data_t               wdata;
    strb_t               sel;
    data_t               exp_rdata;
    logic                exp_err;
    logic [NumCores-1:0] exp_wake;
    logic                exp_eoc;
  } access_t;

  logic                clk;
  logic                rst_n;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  addr_t               wb_adr;
  data_t               wb_dat_w;
  strb_t               wb_sel;
  data_t               wb_dat_r;
  logic                wb_ack;
  logic                wb_err;
  logic                eoc_valid;
  logic [NumCores-1:0] wake_up;

  access_t     accesses [$];
  string       test_names [$];
  data_t       l2_model [L2Size/4]; // Flat word view of L2
  data_t       rom_ref [BootromNumWords];
  data_t       eoc_model;
  int          seed;
  int unsigned cycle_count;
  int unsigned timeout_limit;

  mempool_system #(
    .NumCores    (NumCores    ),
    .TCDMBaseAddr(TCDMBaseAddr),
    .TCDMSize    (TCDMSize    )
  ) u_mempool_system (
    .clk_i      (clk      ),
    .rst_n_i    (rst_n    ),
    .wb_cyc_i   (wb_cyc   ),
    .wb_stb_i   (wb_stb   ),
    .wb_we_i    (wb_we    ),
    .wb_adr_i   (wb_adr   ),
    .wb_dat_i   (wb_dat_w ),
    .wb_sel_i   (wb_sel   ),
    .wb_dat_o   (wb_dat_r ),
    .wb_ack_o   (wb_ack   ),
    .wb_err_o   (wb_err   ),
    .eoc_valid_o(eoc_valid),
    .wake_up_o  (wake_up  )
  );

  always #(ClkHalf) clk = ~clk;

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check(input string name, input data_t expected, input data_t actual);
    if (expected !== actual) begin
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input strb_t sel);
    data_t mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old & ~mask) | (wdata & mask);
  endfunction

  task automatic add_entry(input string name, input logic we, input addr_t adr,
                           input data_t wdata, input strb_t sel, input data_t exp_rdata,
                           input logic exp_err, input logic [NumCores-1:0] exp_wake);
    access_t a;
    a = '{we: we, adr: adr, wdata: wdata, sel: sel, exp_rdata: exp_rdata,
          exp_err: exp_err, exp_wake: exp_wake, exp_eoc: eoc_model[0]};
    accesses.push_back(a);
    test_names.push_back(name);
  endtask

  task automatic l2_write(input string name, input addr_t offset, input data_t d, input strb_t s);
    logic [7:0] idx;
    idx = offset[9:2];
    l2_model[idx] = merge_bytes(l2_model[idx], d, s);
    add_entry(name, 1'b1, L2MemoryBaseAddr + offset, d, s, '0, 1'b0, '0);
  endtask

  task automatic l2_read(input string name, input addr_t offset);
    logic [7:0] idx;
    idx = offset[9:2];
    add_entry(name, 1'b0, L2MemoryBaseAddr + offset, '0, '1, l2_model[idx], 1'b0, '0);
  endtask

  task automatic rom_read(input string name, input addr_t offset);
    logic [3:0] ridx;
    ridx = 4'((offset >> 2) % BootromNumWords); // Word index wraps inside the ROM
    add_entry(name, 1'b0, BootromBaseAddr + offset, '0, '1, rom_ref[ridx], 1'b0, '0);
  endtask

  task automatic ctrl_write(input string name, input addr_t offset, input data_t d,
                            input strb_t s, input logic [NumCores-1:0] exp_wake);
    if (offset == EocOffset) eoc_model = merge_bytes(eoc_model, d, s);
    add_entry(name, 1'b1, CtrlRegistersBaseAddr + offset, d, s, '0, 1'b0, exp_wake);
  endtask

  task automatic ctrl_read(input string name, input addr_t offset, input data_t expected);
    add_entry(name, 1'b0, CtrlRegistersBaseAddr + offset, '0, '1, expected, 1'b0, '0);
  endtask

  task automatic build_table();
    addr_t l2_offsets [8];
    l2_offsets = '{32'h000, 32'h004, 32'h008, 32'h00C, 32'h010, 32'h1F4, 32'h2A8, 32'h3FC};
    foreach (l2_offsets[i]) l2_write("l2_write", l2_offsets[i], data_t'($random(seed)), 4'hF);
    foreach (l2_offsets[i]) l2_read("l2_read", l2_offsets[i]);
    l2_write("l2_partial_write", 32'h008, 32'hA5A5_A5A5, 4'b0101);
    l2_read("l2_partial_read", 32'h008);
    for (int k = 0; k < 16; k++) rom_read("rom_read", addr_t'(4 * k));
    rom_read("rom_wrap_read", 32'h040);
    rom_read("rom_far_read", 32'h1004);
    add_entry("rom_write", 1'b1, BootromBaseAddr + 32'h4, 32'h1234_5678, '1, '0, 1'b1, '0);
    ctrl_read("tcdm_start", TcdmStartOffset, TCDMBaseAddr);
    ctrl_read("tcdm_end", TcdmEndOffset, TCDMBaseAddr + TCDMSize);
    ctrl_read("num_cores", NumCoresOffset, data_t'(NumCores));
    ctrl_write("ro_write", TcdmStartOffset, 32'h1234_5678, '1, '0);
    ctrl_read("ro_unchanged", TcdmStartOffset, TCDMBaseAddr);
    ctrl_read("unknown_offset", 32'h20, '0);
    ctrl_write("eoc_write", EocOffset, 32'hDEAD_BEEF, '1, '0);
    ctrl_read("eoc_read", EocOffset, eoc_model);
    ctrl_write("eoc_byte_write", EocOffset, 32'h0000_0010, 4'b0001, '0);
    ctrl_read("eoc_byte_read", EocOffset, eoc_model);
    ctrl_write("wake_core3", WakeUpOffset, 32'd3, '1, 8'b0000_1000); // Only core 3
    ctrl_write("wake_all", WakeUpOffset, WakeAllCores, '1, '1);
    ctrl_write("wake_none", WakeUpOffset, data_t'(NumCores), '1, '0); // No such core
    add_entry("unmapped_low", 1'b0, 32'h0000_1000, '0, '1, '0, 1'b1, '0);
    add_entry("unmapped_mid", 1'b0, 32'h9000_0000, '0, '1, '0, 1'b1, '0);
    add_entry("l2_past_end", 1'b1, L2MemoryBaseAddr + L2Size, 32'h1, '1, '0, 1'b1, '0);
    l2_read("l2_after_err", 32'h004);
  endtask

  // One Wishbone classic access that holds stb until the cycle after the response
  task automatic run_access(input int idx);
    access_t     a;
    string       name;
    int unsigned cycles;
    a = accesses[idx];
    name = test_names[idx];
    @(posedge clk);
    #2;
    {wb_cyc, wb_stb, wb_we} = {2'b11, a.we};
    wb_adr = a.adr;
    wb_dat_w = a.wdata;
    wb_sel = a.sel;
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
    end while (!wb_ack && !wb_err && cycles < MaxWait);
    check({name, " latency"}, 32'd1, data_t'(cycles));
    check({name, " err"}, data_t'(a.exp_err), data_t'(wb_err));
    check({name, " ack"}, data_t'(!a.exp_err), data_t'(wb_ack));
    if (!a.we && !a.exp_err) check({name, " rdata"}, a.exp_rdata, wb_dat_r);
    check({name, " wake_up"}, data_t'(a.exp_wake), data_t'(wake_up));
    @(posedge clk);
    #2;
    {wb_cyc, wb_stb, wb_we} = 3'b000;
    check({name, " eoc_valid"}, data_t'(a.exp_eoc), data_t'(eoc_valid));
  endtask

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_limit);
      abort_run();
    end
  end

  always @(posedge clk) begin
    #1;
    if (rst_n && !wb_ack) check("wake_up outside ack", '0, data_t'(wake_up));
  end

  initial begin
    {clk, rst_n, wb_cyc, wb_stb, wb_we} = 5'b00000;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_sel = '0;
    seed = 55;
    eoc_model = '0;
    cycle_count = 0;
    $readmemh("bootrom.hex", rom_ref);
    build_table();
    timeout_limit = accesses.size() * 4 + ResetCycles + 50;
    repeat (ResetCycles) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check("reset ack", '0, data_t'(wb_ack));
    check("reset err", '0, data_t'(wb_err));
    check("reset eoc_valid", '0, data_t'(eoc_valid));
    check("reset wake_up", '0, data_t'(wake_up));
    for (int i = 0; i < accesses.size(); i++) run_access(i);
    $display("NO ERRORS");
    $finish;
  end

endmodule : tb_mempool_system

`default_nettype wire

/* bootrom.hex */
// One 32-bit boot ROM word per line, word 0 first
f1402573
00000297
04028293
30529073
10500073
ffdff06f
40000337
00032383
0003a403
00000013
00200113
0ff0000f
00100093
00131313
80000537
00a52023

/* filelist.f */
mempool_pkg.sv
sys_bus_if.sv
soc_addr_decoder.sv
l2_mem.sv
bootrom.sv
ctrl_registers.sv
mempool_system.sv
tb_mempool_system_asserts.sv
tb_mempool_system.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the MemPool system testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
  --top-module tb_mempool_system -f filelist.f -o sim_mempool_system \
  && ./obj_dir/sim_mempool_system | tee /dev/stderr | grep -q "NO ERRORS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
